// File: hw/flash_settings.svh
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// Flash byte address width, as sent in the ADDR phase
`define FLASH_ADDR_W 24

// AXI read data width; bytes per flash read follow from it
`define FLASH_DATA_W 64

// sclk cycles between the last address bit and the first data nibble
`define FLASH_DUMMY_CYCLES 8

// Bus cycles per sclk half period
`define FLASH_SCLK_DIV 1

`endif

// File: hw/flash_pkg.sv
`include "flash_settings.svh"

package flash_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    // AXI4-Lite channel payloads
    typedef struct packed {
        logic [31:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [`FLASH_DATA_W-1:0] data;
        axil_resp_e               resp;
    } axil_r_t;

    typedef struct packed {
        logic [31:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [`FLASH_DATA_W-1:0] data;
        logic [3:0]               strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed {
        logic [`FLASH_ADDR_W-1:0] addr;
    } flash_req_t;

    typedef enum logic [1:0] {
        SEG_SINGLE_OUT,
        SEG_DUMMY,
        SEG_QUAD_IN
    } seg_mode_e;

    // Outgoing data leaves MSB first on io0
    typedef struct packed {
        seg_mode_e   mode;
        logic [31:0] data;
        logic [5:0]  cycles;
    } flash_seg_t;

    typedef enum logic [7:0] {
        OP_QUAD_READ = 8'h6B
    } flash_op_e;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DUMMY,
        DATA,
        WAIT_END
    } seq_state_e;

endpackage

// File: hw/axil_read_front.sv
`include "flash_settings.svh"

module axil_read_front import flash_pkg::*; (
    input  logic                     bus,
    input  logic                     rst,
    input  axil_ar_t                 ar,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    output axil_r_t                  r,
    output logic                     r_valid,
    input  logic                     r_ready,
    input  axil_aw_t                 aw,
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  axil_w_t                  w,
    input  logic                     w_valid,
    output logic                     w_ready,
    output axil_b_t                  b,
    output logic                     b_valid,
    input  logic                     b_ready,
    output flash_req_t               req,
    output logic                     req_valid,
    input  logic                     req_ready,
    input  logic [`FLASH_DATA_W-1:0] word,
    input  logic                     word_valid,
    output logic                     word_ready
);

    logic write_start;

    // Assembled word goes straight onto the read data channel
    assign r          = '{data: word, resp: OKAY};
    assign r_valid    = word_valid;
    assign word_ready = r_ready;

    // One read in flight: the address port reopens after the response is taken
    always_ff @(posedge bus) begin
        if (rst) begin
            ar_ready  <= 1'b1;
            req_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                ar_ready  <= 1'b0;
                req_valid <= 1'b1;
            end else if (r_valid && r_ready) begin
                ar_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (ar_valid && ar_ready) begin
            req.addr <= ar.addr[`FLASH_ADDR_W-1:0];
        end
    end

    // Writes are taken in pairs and always refused
    assign write_start = aw_valid && w_valid && !aw_ready && !b_valid;
    assign b           = '{resp: SLVERR};

    always_ff @(posedge bus) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            aw_ready <= write_start;
            w_ready  <= write_start;
            if (aw_valid && aw_ready && w_valid && w_ready) begin
                b_valid <= 1'b1;
            end else if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // The sequencer must be idle whenever a new request is offered
    assert property (@(posedge bus) disable iff (rst) req_valid |-> req_ready);

    assert property (@(posedge bus) disable iff (rst) r_valid |-> !ar_ready);

    // Master side holds write payloads until accepted
    assert property (@(posedge bus) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw));
    assert property (@(posedge bus) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w));

endmodule

// File: hw/flash_cmd_seq.sv
`include "flash_settings.svh"

module flash_cmd_seq import flash_pkg::*; (
    input  logic       bus,
    input  logic       rst,
    input  flash_req_t req,
    input  logic       req_valid,
    output logic       req_ready,
    output flash_seg_t seg,
    output logic       seg_valid,
    input  logic       seg_ready,
    input  logic       seg_done,
    output logic       cs
);

    localparam int BYTES = `FLASH_DATA_W / 8;

    seq_state_e state;
    flash_req_t req_q;

    function automatic flash_seg_t mk_seg(seg_mode_e m, logic [31:0] d, logic [5:0] n);
        flash_seg_t s;
        s.mode   = m;
        s.data   = d;
        s.cycles = n;
        return s;
    endfunction

    assign req_ready = (state == IDLE);

    always_ff @(posedge bus) begin
        if (rst) begin
            state     <= IDLE;
            seg_valid <= 1'b0;
            cs        <= 1'b1;
        end else begin
            if (seg_valid && seg_ready) begin
                seg_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        seg_valid <= 1'b1;
                        state     <= CMD;
                    end
                end
                CMD: begin
                    // Select the flash as the command starts shifting
                    if (seg_valid && seg_ready) begin
                        cs <= 1'b0;
                    end
                    if (seg_done) begin
                        seg_valid <= 1'b1;
                        state     <= ADDR;
                    end
                end
                ADDR: begin
                    if (seg_done) begin
                        seg_valid <= 1'b1;
                        state     <= DUMMY;
                    end
                end
                DUMMY: begin
                    if (seg_done) begin
                        seg_valid <= 1'b1;
                        state     <= DATA;
                    end
                end
                DATA: begin
                    if (seg_done) begin
                        cs    <= 1'b1;
                        state <= WAIT_END;
                    end
                end
                // One cycle of cs high before the next request
                WAIT_END: state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Segment payloads
    always_ff @(posedge bus) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
            seg   <= mk_seg(SEG_SINGLE_OUT, {OP_QUAD_READ, 24'h0}, 6'd8);
        end else if (seg_done) begin
            case (state)
                CMD: seg <= mk_seg(SEG_SINGLE_OUT,
                                   {req_q.addr, {(32 - `FLASH_ADDR_W){1'b0}}},
                                   6'(`FLASH_ADDR_W));
                ADDR: seg <= mk_seg(SEG_DUMMY, 32'h0, 6'(`FLASH_DUMMY_CYCLES));
                // Two nibbles per byte
                DUMMY: seg <= mk_seg(SEG_QUAD_IN, 32'h0, 6'(2 * BYTES));
                default: seg <= seg;
            endcase
        end
    end

    assert property (@(posedge bus) disable iff (rst)
        state inside {ADDR, DUMMY, DATA} |-> !cs);

    // Shifter is idle whenever a segment is offered
    assert property (@(posedge bus) disable iff (rst) seg_valid |-> seg_ready);

endmodule

// File: hw/qspi_shifter.sv
`include "flash_settings.svh"

module qspi_shifter import flash_pkg::*; (
    input  logic       bus,
    input  logic       rst,
    input  flash_seg_t seg,
    input  logic       seg_valid,
    output logic       seg_ready,
    output logic       seg_done,
    output logic       sclk,
    inout  logic [3:0] io,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic        busy;
    logic [7:0]  div_cnt;
    logic        half_tick;
    logic        rise_tick;
    logic        fall_tick;
    logic        nib_low;
    seg_mode_e   mode;
    logic [31:0] shift;
    logic [5:0]  left;
    logic [3:0]  hi_nib;

    assign seg_ready = !busy;
    assign half_tick = busy && (div_cnt == 8'(`FLASH_SCLK_DIV - 1));
    assign rise_tick = half_tick && !sclk;
    assign fall_tick = half_tick && sclk;

    // WP and HOLD stay high until the flash takes over the bus
    assign io[0] = (busy && mode == SEG_SINGLE_OUT) ? shift[31] : 1'bz;
    assign io[1] = 1'bz;
    assign io[3:2] = (busy && mode == SEG_QUAD_IN) ? 2'bzz : 2'b11;

    always_ff @(posedge bus) begin
        if (rst) begin
            busy     <= 1'b0;
            sclk     <= 1'b0;
            div_cnt  <= 8'd0;
            seg_done <= 1'b0;
            rx_valid <= 1'b0;
            nib_low  <= 1'b0;
        end else begin
            seg_done <= 1'b0;
            rx_valid <= 1'b0;
            if (seg_valid && seg_ready) begin
                busy    <= 1'b1;
                div_cnt <= 8'd0;
                nib_low <= 1'b0;
            end else if (half_tick) begin
                div_cnt <= 8'd0;
                sclk    <= !sclk;
                if (rise_tick && mode == SEG_QUAD_IN) begin
                    nib_low  <= !nib_low;
                    rx_valid <= nib_low;
                end
                // Segment ends on its last falling edge
                if (fall_tick && left == 6'd1) begin
                    busy     <= 1'b0;
                    seg_done <= 1'b1;
                end
            end else if (busy) begin
                div_cnt <= div_cnt + 8'd1;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (seg_valid && seg_ready) begin
            mode  <= seg.mode;
            shift <= seg.data;
            left  <= seg.cycles;
        end else if (fall_tick) begin
            shift <= {shift[30:0], 1'b0};
            left  <= left - 6'd1;
        end
        // High nibble arrives first
        if (rise_tick && mode == SEG_QUAD_IN) begin
            if (nib_low) begin
                rx_byte <= {hi_nib, io};
            end else begin
                hi_nib <= io;
            end
        end
    end

endmodule

// File: hw/word_assembler.sv
`include "flash_settings.svh"

module word_assembler (
    input  logic                     bus,
    input  logic                     rst,
    input  logic [7:0]               rx_byte,
    input  logic                     rx_valid,
    output logic [`FLASH_DATA_W-1:0] word,
    output logic                     word_valid,
    input  logic                     word_ready
);

    localparam int BYTES = `FLASH_DATA_W / 8;
    localparam int CNT_W = $clog2(BYTES);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge bus) begin
        if (rst) begin
            cnt        <= '0;
            word_valid <= 1'b0;
        end else begin
            if (rx_valid) begin
                if (cnt == CNT_W'(BYTES - 1)) begin
                    cnt        <= '0;
                    word_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (word_valid && word_ready) begin
                word_valid <= 1'b0;
            end
        end
    end

    // New bytes enter at the top so the first byte lands in word[7:0]
    always_ff @(posedge bus) begin
        if (rx_valid) begin
            word <= {rx_byte, word[`FLASH_DATA_W-1:8]};
        end
    end

    // A held word is never overwritten by a following read
    assert property (@(posedge bus) disable iff (rst) rx_valid |-> !word_valid);

endmodule

// File: hw/axil_flash_top.sv
`include "flash_settings.svh"

module axil_flash_top import flash_pkg::*; (
    input  logic       bus,
    input  logic       rst,
    input  axil_ar_t   ar,
    input  logic       ar_valid,
    output logic       ar_ready,
    output axil_r_t    r,
    output logic       r_valid,
    input  logic       r_ready,
    input  axil_aw_t   aw,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  axil_w_t    w,
    input  logic       w_valid,
    output logic       w_ready,
    output axil_b_t    b,
    output logic       b_valid,
    input  logic       b_ready,
    output logic       cs,
    output logic       sclk,
    inout  logic [3:0] io
);

    flash_req_t               req;
    logic                     req_valid;
    logic                     req_ready;
    flash_seg_t               seg;
    logic                     seg_valid;
    logic                     seg_ready;
    logic                     seg_done;
    logic [7:0]               rx_byte;
    logic                     rx_valid;
    logic [`FLASH_DATA_W-1:0] word;
    logic                     word_valid;
    logic                     word_ready;

    axil_read_front axil_read_front_inst (
        .bus, .rst,
        .ar, .ar_valid, .ar_ready,
        .r, .r_valid, .r_ready,
        .aw, .aw_valid, .aw_ready,
        .w, .w_valid, .w_ready,
        .b, .b_valid, .b_ready,
        .req, .req_valid, .req_ready,
        .word, .word_valid, .word_ready
    );

    flash_cmd_seq flash_cmd_seq_inst (
        .bus, .rst,
        .req, .req_valid, .req_ready,
        .seg, .seg_valid, .seg_ready, .seg_done,
        .cs
    );

    qspi_shifter qspi_shifter_inst (
        .bus, .rst,
        .seg, .seg_valid, .seg_ready, .seg_done,
        .sclk, .io,
        .rx_byte, .rx_valid
    );

    word_assembler word_assembler_inst (
        .bus, .rst,
        .rx_byte, .rx_valid,
        .word, .word_valid, .word_ready
    );

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic bus,
    output logic rst
);

    // Period of 100, rising edges at 50, 150, ...
    initial begin
        bus = 1'b0;
        forever #50 bus = ~bus;
    end

    // Reset held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge bus);
        #10;
        rst = 1'b0;
    end

endmodule

// File: tb/qspi_flash_model.sv
module qspi_flash_model (
    input  logic       cs,
    input  logic       sclk,
    inout  logic [3:0] io
);

    localparam int OPCODE_BITS = 8;
    localparam int ADDR_BITS   = 24;
    localparam int DUMMY_CLKS  = 8;
    localparam int DATA_START  = OPCODE_BITS + ADDR_BITS + DUMMY_CLKS;

    int unsigned edges = 0;
    int unsigned n;
    logic [7:0]  opcode;
    logic [23:0] addr;
    logic [7:0]  data;
    logic [3:0]  nib;
    logic        drive = 1'b0;

    assign io = drive ? nib : 4'bzzzz;

    // Array contents as a function of the byte address
    function automatic logic [7:0] pattern_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // Every select starts a new command
    always @(negedge cs) begin
        edges = 0;
        drive = 1'b0;
    end

    always @(posedge cs) begin
        drive = 1'b0;
    end

    // Opcode and address come in on io0, MSB first
    always @(posedge sclk) begin
        if (cs === 1'b0) begin
            if (edges < OPCODE_BITS) begin
                opcode = {opcode[6:0], io[0]};
            end else if (edges < OPCODE_BITS + ADDR_BITS) begin
                addr = {addr[22:0], io[0]};
            end
            edges++;
        end
    end

    // Data nibbles change on the falling edge, high nibble first
    always @(negedge sclk) begin
        if (cs === 1'b0 && opcode == 8'h6B && edges >= DATA_START) begin
            n     = edges - DATA_START;
            data  = pattern_byte(addr + 24'(n / 2));
            nib   = n[0] ? data[3:0] : data[7:4];
            drive = 1'b1;
        end
    end

endmodule

// File: tb/axil_flash_tb.sv
`include "flash_settings.svh"

module axil_flash_tb import flash_pkg::*; ();

    localparam int N_FIXED   = 8;
    localparam int N_RAND    = 6;
    localparam int N_ENTRIES = N_FIXED + N_RAND;
    // Command, address, dummy, then two nibbles per data byte
    localparam int EDGES_PER_READ = 8 + `FLASH_ADDR_W + `FLASH_DUMMY_CYCLES
                                    + 2 * (`FLASH_DATA_W / 8);

    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [3:0]  stall;
        axil_resp_e  resp;
    } entry_t;

    // Operation, address, response stall, expected response
    localparam entry_t FIXED [N_FIXED] = '{
        '{1'b0, 32'h0000_0000, 4'd0, OKAY},
        '{1'b0, 32'h0000_0123, 4'd3, OKAY},
        '{1'b1, 32'h0000_0123, 4'd2, SLVERR},
        '{1'b0, 32'h0000_0123, 4'd0, OKAY},
        '{1'b0, 32'h12AB_CDEF, 4'd5, OKAY},
        '{1'b1, 32'h0000_0040, 4'd0, SLVERR},
        '{1'b0, 32'h00FF_FFFC, 4'd1, OKAY},
        '{1'b0, 32'h0000_0040, 4'd0, OKAY}
    };

    logic       bus;
    logic       rst;
    axil_ar_t   ar;
    logic       ar_valid;
    logic       ar_ready;
    axil_r_t    r;
    logic       r_valid;
    logic       r_ready;
    axil_aw_t   aw;
    logic       aw_valid;
    logic       aw_ready;
    axil_w_t    w;
    logic       w_valid;
    logic       w_ready;
    axil_b_t    b;
    logic       b_valid;
    logic       b_ready;
    logic       cs;
    logic       sclk;
    wire  [3:0] io;

    entry_t table_q[$];
    integer seed       = 82073;
    int     errors     = 0;
    int     reads_done = 0;
    int     sclk_edges = 0;
    int     cs_windows = 0;
    logic   in_window  = 1'b0;

    tb_clock_gen tb_clock_gen_inst (.bus, .rst);

    axil_flash_top axil_flash_top_inst (
        .bus, .rst,
        .ar, .ar_valid, .ar_ready,
        .r, .r_valid, .r_ready,
        .aw, .aw_valid, .aw_ready,
        .w, .w_valid, .w_ready,
        .b, .b_valid, .b_ready,
        .cs, .sclk, .io
    );

    qspi_flash_model qspi_flash_model_inst (.cs, .sclk, .io);

    // Eight bytes from addr upward with the first byte in the low byte
    function automatic logic [63:0] expected_word(input logic [23:0] a);
        logic [63:0] wd;
        logic [23:0] ba;
        int          i;
        for (i = 0; i < 8; i++) begin
            ba = a + 24'(i);
            wd[8*i +: 8] = ba[7:0] ^ ba[15:8] ^ 8'h5A;
        end
        return wd;
    endfunction

    task automatic compare_hex(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        if (got !== exp) begin
            $display("Fail %s expected 0x%0h actual 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic next_drive_slot();
        @(posedge bus);
        #10;
    endtask

    task automatic run_read(input entry_t e);
        logic [63:0] held;
        int          k;
        next_drive_slot();
        ar.addr  = e.addr;
        ar_valid = 1'b1;
        @(negedge bus);
        while (!ar_ready) @(negedge bus);
        next_drive_slot();
        ar_valid = 1'b0;
        @(negedge bus);
        while (!r_valid) begin
            if (ar_ready) begin
                $display("Address port reopened before the read response");
                errors++;
            end
            @(negedge bus);
        end
        compare_hex("r.data", expected_word(e.addr[23:0]), r.data);
        compare_hex("r.resp", e.resp, r.resp);
        held = r.data;
        for (k = 0; k < e.stall; k++) begin
            @(negedge bus);
            compare_hex("r_valid", 1, r_valid);
            compare_hex("r.data", held, r.data);
            compare_hex("ar_ready", 0, ar_ready);
        end
        next_drive_slot();
        r_ready = 1'b1;
        next_drive_slot();
        r_ready = 1'b0;
        @(negedge bus);
        compare_hex("r_valid", 0, r_valid);
        compare_hex("ar_ready", 1, ar_ready);
        compare_hex("cs", 1, cs);
        reads_done++;
    endtask

    task automatic run_write(input entry_t e);
        int k;
        next_drive_slot();
        aw.addr  = e.addr;
        w.data   = {2{e.addr}};
        w.strb   = 4'hF;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        @(negedge bus);
        while (!aw_ready) @(negedge bus);
        compare_hex("w_ready", 1, w_ready);
        next_drive_slot();
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        @(negedge bus);
        while (!b_valid) @(negedge bus);
        compare_hex("b.resp", e.resp, b.resp);
        for (k = 0; k < e.stall; k++) begin
            @(negedge bus);
            compare_hex("b_valid", 1, b_valid);
        end
        next_drive_slot();
        b_ready = 1'b1;
        next_drive_slot();
        b_ready = 1'b0;
        @(negedge bus);
        compare_hex("b_valid", 0, b_valid);
    endtask

    // Pin monitor for the sclk count of each select
    always @(negedge cs) begin
        sclk_edges = 0;
        in_window  = 1'b1;
    end

    always @(posedge sclk) begin
        if (cs !== 1'b0) begin
            $display("sclk rose while the flash was not selected");
            errors++;
        end else begin
            sclk_edges++;
        end
    end

    always @(posedge cs) begin
        if (in_window) begin
            in_window = 1'b0;
            cs_windows++;
            compare_hex("sclk rising edges", EDGES_PER_READ, sclk_edges);
        end
    end

    initial begin : stimulus
        entry_t e;
        int     i;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        for (i = 0; i < N_FIXED; i++) begin
            table_q.push_back(FIXED[i]);
        end
        // Back-to-back reads at random addresses
        for (i = 0; i < N_RAND; i++) begin
            e.is_write = 1'b0;
            e.addr     = $random(seed);
            e.stall    = 4'($random(seed)) & 4'h3;
            e.resp     = OKAY;
            table_q.push_back(e);
        end
        @(negedge rst);
        @(negedge bus);
        compare_hex("ar_ready", 1, ar_ready);
        compare_hex("aw_ready", 0, aw_ready);
        compare_hex("w_ready", 0, w_ready);
        compare_hex("r_valid", 0, r_valid);
        compare_hex("b_valid", 0, b_valid);
        compare_hex("cs", 1, cs);
        compare_hex("sclk", 0, sclk);
        for (i = 0; i < table_q.size(); i++) begin
            if (table_q[i].is_write) begin
                run_write(table_q[i]);
            end else begin
                run_read(table_q[i]);
            end
        end
        repeat (4) @(negedge bus);
        compare_hex("cs select count", reads_done, cs_windows);
        $display("Run complete: %0d entries, %0d errors", N_ENTRIES, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(N_ENTRIES * 300 * 100);
        $display("Timeout: the table of tests did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+hw
hw/flash_pkg.sv
hw/axil_read_front.sv
hw/flash_cmd_seq.sv
hw/qspi_shifter.sv
hw/word_assembler.sv
hw/axil_flash_top.sv
tb/tb_clock_gen.sv
tb/qspi_flash_model.sv
tb/axil_flash_tb.sv

// File: Bender.yml
package:
  name: axil_flash

sources:
  - include_dirs:
      - hw
    files:
      - hw/flash_pkg.sv
      - hw/axil_read_front.sv
      - hw/flash_cmd_seq.sv
      - hw/qspi_shifter.sv
      - hw/word_assembler.sv
      - hw/axil_flash_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_clock_gen.sv
      - tb/qspi_flash_model.sv
      - tb/axil_flash_tb.sv
